// ==== hdl/mpf_pkg.sv ====
// Shared sizing for the read reorder shim stack.
// The RTL and the testbench both pull their widths from here.
package mpf_pkg;

    // ========================================================================
    // Request and response field widths
    // ========================================================================

    // Line address carried by an AFU read request
    localparam int ADDR_WIDTH = 16;

    // One response line returned by the FIU
    localparam int DATA_WIDTH = 64;

    // AFU metadata tag, returned untouched with the matching response
    localparam int MDATA_WIDTH = 8;

    // ========================================================================
    // Reorder buffer sizing
    // ========================================================================

    // Number of reorder slots, which bounds the reads in flight.
    // Must stay a power of two so that slot pointers wrap naturally
    localparam int ROB_DEPTH = 16;

    // Slot tag width, this is what the FIU sees in place of mdata
    localparam int SLOT_WIDTH = $clog2(ROB_DEPTH);

    // Requests the AFU may still send once almost-full has been raised
    localparam int ALMOST_FULL_SLACK = 2;

    // Outstanding counter needs one extra bit to hold ROB_DEPTH itself
    localparam int COUNT_WIDTH = SLOT_WIDTH + 1;

    // Outstanding level at which almost-full is raised
    localparam logic [COUNT_WIDTH-1:0] AFULL_LEVEL =
        COUNT_WIDTH'(ROB_DEPTH - ALMOST_FULL_SLACK);

endpackage

// ==== hdl/mpf_slot_alloc.sv ====
`timescale 1ns/100ps

// Producer side of the reorder stack.
// Each AFU read takes the next reorder slot in order. The original mdata is
// parked in the mdata buffer at that slot and the FIU only ever sees the slot.
module mpf_slot_alloc
(
    input  logic                            clk,
    input  logic                            rst,

    // AFU read request strobe
    input  logic                            afu_req_valid,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0]  afu_req_addr,
    input  logic [mpf_pkg::MDATA_WIDTH-1:0] afu_req_mdata,

    // One slot handed back by the drain
    input  logic                            slot_free,

    // Registered FIU read request
    output logic                            fiu_req_valid,
    output logic [mpf_pkg::ADDR_WIDTH-1:0]  fiu_req_addr,
    output logic [mpf_pkg::SLOT_WIDTH-1:0]  fiu_req_tag,

    // Write port of the mdata buffer
    output logic                            mdata_wr_en,
    output logic [mpf_pkg::SLOT_WIDTH-1:0]  mdata_wr_slot,
    output logic [mpf_pkg::MDATA_WIDTH-1:0] mdata_wr_data,

    // Flow control toward the AFU
    output logic                            afu_almost_full
);

    import mpf_pkg::*;

    // Next slot to hand out, wraps at ROB_DEPTH
    logic [SLOT_WIDTH-1:0]  alloc_slot;

    // Slots allocated and not yet released
    logic [COUNT_WIDTH-1:0] out_count;
    logic [COUNT_WIDTH-1:0] count_next;

    // Save the caller's mdata in the same cycle the slot is taken
    assign mdata_wr_en   = afu_req_valid;
    assign mdata_wr_slot = alloc_slot;
    assign mdata_wr_data = afu_req_mdata;

    // Allocation and release in the same cycle cancel out
    always_comb
    begin
        count_next = out_count;
        if (afu_req_valid && !slot_free)
        begin
            count_next = out_count + 1'b1;
        end
        else if (!afu_req_valid && slot_free)
        begin
            count_next = out_count - 1'b1;
        end
    end

    // Control state: pointer, counter, strobe and almost-full
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alloc_slot      <= '0;
            out_count       <= '0;
            fiu_req_valid   <= 1'b0;
            afu_almost_full <= 1'b0;
        end
        else
        begin
            out_count       <= count_next;
            fiu_req_valid   <= afu_req_valid;
            // Judged on the count after this cycle's traffic
            afu_almost_full <= (count_next >= AFULL_LEVEL);
            if (afu_req_valid)
            begin
                alloc_slot <= alloc_slot + 1'b1;
            end
        end
    end

    // FIU request payload, qualified by fiu_req_valid
    always_ff @(posedge clk)
    begin
        if (afu_req_valid)
        begin
            fiu_req_addr <= afu_req_addr;
            fiu_req_tag  <= alloc_slot;
        end
    end

endmodule

// ==== hdl/mpf_reorder_buf.sv ====
`timescale 1ns/100ps

// Slot-indexed storage for the reorder stack.
// Writes land at any slot in any order; reads only ever come from the head,
// which walks the slots in allocation order.
module mpf_reorder_buf
#(
    parameter type payload_t = logic [mpf_pkg::DATA_WIDTH-1:0]
)
(
    input  logic                           clk,
    input  logic                           rst,

    // Write port, one slot per strobe
    input  logic                           wr_en,
    input  logic [mpf_pkg::SLOT_WIDTH-1:0] wr_slot,
    input  payload_t                       wr_data,

    // Retire the head slot and step to the next one
    input  logic                           rd_release,

    // Head of the buffer
    output logic [mpf_pkg::SLOT_WIDTH-1:0] head_slot,
    output logic                           head_valid,
    output payload_t                       head_data
);

    import mpf_pkg::*;

    payload_t              mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  slot_valid;
    logic [SLOT_WIDTH-1:0] head;

    assign head_slot  = head;
    assign head_valid = slot_valid[head];
    assign head_data  = mem[head];

    // Valid bits and the head pointer
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slot_valid <= '0;
            head       <= '0;
        end
        else
        begin
            if (rd_release)
            begin
                slot_valid[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            // A write never targets the slot being retired, set comes last anyway
            if (wr_en)
            begin
                slot_valid[wr_slot] <= 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_slot] <= wr_data;
        end
    end

endmodule

// ==== hdl/mpf_rsp_drain.sv ====
`timescale 1ns/100ps

// Consumer side of the reorder stack.
// Pulls responses off the head of the buffer strictly in order, pairs each
// with the mdata the AFU originally supplied and returns it through two
// register stages.
module mpf_rsp_drain
(
    input  logic                            clk,
    input  logic                            rst,

    // Head of the response buffer and the mdata saved for the same slot
    input  logic                            head_valid,
    input  logic [mpf_pkg::DATA_WIDTH-1:0]  head_data,
    input  logic [mpf_pkg::MDATA_WIDTH-1:0] head_mdata,

    // Retires the head slot in both buffers and frees it for allocation
    output logic                            rd_release,

    // Registered AFU response strobe
    output logic                            afu_rsp_valid,
    output logic [mpf_pkg::DATA_WIDTH-1:0]  afu_rsp_data,
    output logic [mpf_pkg::MDATA_WIDTH-1:0] afu_rsp_mdata
);

    import mpf_pkg::*;

    // ========================================================================
    // Stage 1: release the head and capture it
    // ========================================================================

    logic                   pipe_valid;
    logic [DATA_WIDTH-1:0]  pipe_data;
    logic [MDATA_WIDTH-1:0] pipe_mdata;

    // The AFU never stalls, so any valid head can leave right away.
    // This lets a run of ready slots drain one per cycle
    assign rd_release = head_valid;

    always_ff @(posedge clk)
    begin
        if (head_valid)
        begin
            pipe_data  <= head_data;
            pipe_mdata <= head_mdata;
        end
    end

    // ========================================================================
    // Stage 2: output register toward the AFU
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (pipe_valid)
        begin
            afu_rsp_data  <= pipe_data;
            afu_rsp_mdata <= pipe_mdata;
        end
    end

    // Strobes for both stages
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pipe_valid    <= 1'b0;
            afu_rsp_valid <= 1'b0;
        end
        else
        begin
            pipe_valid    <= head_valid;
            afu_rsp_valid <= pipe_valid;
        end
    end

endmodule

// ==== hdl/mpf_lite.sv ====
`timescale 1ns/100ps

// Read-only reorder shim between an accelerator and a memory port.
// Requests flow up from the AFU through the allocator, responses flow down
// from the FIU through the buffers and the drain.
module mpf_lite
(
    input  logic                            clk,
    input  logic                            rst,

    // AFU read requests
    input  logic                            afu_req_valid,
    input  logic [mpf_pkg::ADDR_WIDTH-1:0]  afu_req_addr,
    input  logic [mpf_pkg::MDATA_WIDTH-1:0] afu_req_mdata,
    output logic                            afu_almost_full,

    // FIU read requests, tagged by slot
    output logic                            fiu_req_valid,
    output logic [mpf_pkg::ADDR_WIDTH-1:0]  fiu_req_addr,
    output logic [mpf_pkg::SLOT_WIDTH-1:0]  fiu_req_tag,

    // FIU read responses, in any order
    input  logic                            fiu_rsp_valid,
    input  logic [mpf_pkg::SLOT_WIDTH-1:0]  fiu_rsp_tag,
    input  logic [mpf_pkg::DATA_WIDTH-1:0]  fiu_rsp_data,

    // AFU read responses, in request order
    output logic                            afu_rsp_valid,
    output logic [mpf_pkg::DATA_WIDTH-1:0]  afu_rsp_data,
    output logic [mpf_pkg::MDATA_WIDTH-1:0] afu_rsp_mdata
);

    import mpf_pkg::*;

    logic                   mdata_wr_en;
    logic [SLOT_WIDTH-1:0]  mdata_wr_slot;
    logic [MDATA_WIDTH-1:0] mdata_wr_data;

    logic                   rd_release;
    logic                   head_valid;
    logic [DATA_WIDTH-1:0]  head_data;
    logic [MDATA_WIDTH-1:0] head_mdata;

    // ========================================================================
    // Request path that takes a slot, stashes the mdata and tags the FIU request
    // ========================================================================

    mpf_slot_alloc slot_alloc
    (
        .clk,
        .rst,
        .afu_req_valid,
        .afu_req_addr,
        .afu_req_mdata,
        .slot_free(rd_release),
        .fiu_req_valid,
        .fiu_req_addr,
        .fiu_req_tag,
        .mdata_wr_en,
        .mdata_wr_slot,
        .mdata_wr_data,
        .afu_almost_full
    );

    // ========================================================================
    // Reorder storage with one instance per payload
    // ========================================================================

    // Responses are written straight from the FIU at their slot.
    // Its head pointer is the in-order read position of the whole stack
    mpf_reorder_buf #(.payload_t(logic [DATA_WIDTH-1:0])) rsp_buf
    (
        .clk,
        .rst,
        .wr_en(fiu_rsp_valid),
        .wr_slot(fiu_rsp_tag),
        .wr_data(fiu_rsp_data),
        .rd_release,
        .head_slot(),
        .head_valid,
        .head_data
    );

    // Both heads step together on rd_release, so this head tracks the rsp_buf head
    mpf_reorder_buf #(.payload_t(logic [MDATA_WIDTH-1:0])) mdata_buf
    (
        .clk,
        .rst,
        .wr_en(mdata_wr_en),
        .wr_slot(mdata_wr_slot),
        .wr_data(mdata_wr_data),
        .rd_release,
        .head_slot(),
        .head_valid(),
        .head_data(head_mdata)
    );

    // ========================================================================
    // Response path with an in-order drain and a registered output to the AFU
    // ========================================================================

    mpf_rsp_drain rsp_drain
    (
        .clk,
        .rst,
        .head_valid,
        .head_data,
        .head_mdata,
        .rd_release,
        .afu_rsp_valid,
        .afu_rsp_data,
        .afu_rsp_mdata
    );

endmodule

// ==== tests/mpf_lite_sva.sv ====
`timescale 1ns/100ps

// Protocol assertions for the reorder shim, bound into mpf_lite.
// The slot count is rebuilt here from the allocation and release strobes.
module mpf_lite_sva
(
    input logic clk,
    input logic rst,
    input logic afu_req_valid,
    input logic fiu_req_valid,
    input logic afu_rsp_valid,
    input logic rd_release
);

    import mpf_pkg::*;

    // Slots allocated and not yet released
    logic [COUNT_WIDTH-1:0] live_count;

    always_ff @(posedge clk)
    begin
        if (rst)
            live_count <= '0;
        else if (afu_req_valid && !rd_release)
            live_count <= live_count + 1'b1;
        else if (!afu_req_valid && rd_release)
            live_count <= live_count - 1'b1;
    end

    // With every slot taken, a new request would overwrite a live slot
    no_req_when_full: assert property (@(posedge clk) disable iff (rst)
        (live_count == COUNT_WIDTH'(ROB_DEPTH)) |=> !fiu_req_valid)
        else $error("FIU request issued while every reorder slot was in use");

    // Both outbound strobes come out of reset low
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!afu_rsp_valid && !fiu_req_valid))
        else $error("strobe high in the cycle after reset");

    // FIU request is the AFU request one cycle later, never more, never less
    req_follows: assert property (@(posedge clk) disable iff (rst)
        afu_req_valid |=> fiu_req_valid)
        else $error("AFU request not forwarded to the FIU after one cycle");

    no_stray_req: assert property (@(posedge clk) disable iff (rst)
        !afu_req_valid |=> !fiu_req_valid)
        else $error("FIU request without a matching AFU request");

endmodule

bind mpf_lite mpf_lite_sva sva
(
    .clk(clk),
    .rst(rst),
    .afu_req_valid(afu_req_valid),
    .fiu_req_valid(fiu_req_valid),
    .afu_rsp_valid(afu_rsp_valid),
    .rd_release(rd_release)
);

// ==== tests/tb_mpf_lite.sv ====
`timescale 1ns/100ps

// Testbench for the read reorder shim.
// A random AFU issues reads, a behavioral FIU returns them in any order, and a
// scoreboard checks that responses come back in issue order with their mdata.
module tb_mpf_lite;

    import mpf_pkg::*;

    typedef enum int {REQ_OFF, REQ_RANDOM, REQ_GATED, REQ_FORCE} req_mode_t;
    typedef enum int {FIU_HOLD, FIU_RANDOM, FIU_REVERSE} fiu_mode_t;

    logic                   clk;
    logic                   rst;
    logic                   afu_req_valid;
    logic [ADDR_WIDTH-1:0]  afu_req_addr;
    logic [MDATA_WIDTH-1:0] afu_req_mdata;
    logic                   afu_almost_full;
    logic                   fiu_req_valid;
    logic [ADDR_WIDTH-1:0]  fiu_req_addr;
    logic [SLOT_WIDTH-1:0]  fiu_req_tag;
    logic                   fiu_rsp_valid;
    logic [SLOT_WIDTH-1:0]  fiu_rsp_tag;
    logic [DATA_WIDTH-1:0]  fiu_rsp_data;
    logic                   afu_rsp_valid;
    logic [DATA_WIDTH-1:0]  afu_rsp_data;
    logic [MDATA_WIDTH-1:0] afu_rsp_mdata;

    // Scoreboard of AFU reads in issue order
    logic [ADDR_WIDTH-1:0]  sb_addr [$];
    logic [MDATA_WIDTH-1:0] sb_mdata [$];

    // Reads the FIU model has seen and not yet answered
    logic [SLOT_WIDTH-1:0]  pend_tag [$];
    logic [ADDR_WIDTH-1:0]  pend_addr [$];

    logic [31:0]            rng;
    int                     cycle;
    int                     issued;
    int                     rsp_count;
    logic                   prev_req_valid;
    logic [ADDR_WIDTH-1:0]  prev_req_addr;
    logic [SLOT_WIDTH-1:0]  exp_tag;
    fiu_mode_t              fiu_mode;

    // Almost-full model that only applies while the FIU holds every response
    bit                     af_model_on;
    int                     held_count;

    // Bookkeeping for the reverse-order burst
    bit                     burst_on;
    int                     burst_base;
    int                     last_strobe_cycle;
    int                     last_rsp_cycle;

    mpf_lite DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================================
    // Reporting
    // ========================================================================

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ========================================================================
    // Monitors sampled at the falling edge where outputs are settled
    // ========================================================================

    // Each FIU request must echo last cycle's AFU request, tagged in slot order
    task automatic watch_fiu_req();
        check_value("fiu_req_valid", 64'(fiu_req_valid), 64'(prev_req_valid));
        if (fiu_req_valid)
        begin
            check_value("fiu_req_addr", 64'(fiu_req_addr), 64'(prev_req_addr));
            check_value("fiu_req_tag", 64'(fiu_req_tag), 64'(exp_tag));
            foreach (pend_tag[i])
            begin
                if (pend_tag[i] == fiu_req_tag)
                    report_error("FIU tag issued again while still pending");
            end
            pend_tag.push_back(fiu_req_tag);
            pend_addr.push_back(fiu_req_addr);
            // Tags wrap at ROB_DEPTH through the natural width of the slot tag
            exp_tag = exp_tag + 1'b1;
        end
    endtask

    task automatic watch_afu_rsp();
        logic [ADDR_WIDTH-1:0]  exp_addr;
        logic [MDATA_WIDTH-1:0] exp_mdata;
        int                     j;
        if (afu_rsp_valid)
        begin
            if (sb_addr.size() == 0)
                report_error("AFU response arrived with no read outstanding");
            exp_addr  = sb_addr.pop_front();
            exp_mdata = sb_mdata.pop_front();
            check_value("afu_rsp_data", afu_rsp_data, {4{exp_addr}});
            check_value("afu_rsp_mdata", 64'(afu_rsp_mdata), 64'(exp_mdata));
            rsp_count++;
            if (burst_on)
            begin
                j = rsp_count - burst_base;
                // The head strobe reaches the AFU 3 cycles later, then one per cycle
                if (j == 1)
                    check_value("afu_rsp_valid latency", 64'(cycle - last_strobe_cycle), 64'(3));
                else
                    check_value("afu_rsp_valid gap", 64'(cycle - last_rsp_cycle), 64'(1));
                // Response j shows up while release j+1 is already counted
                check_value("afu_almost_full", 64'(afu_almost_full),
                            64'((ROB_DEPTH - (j + 1)) >= (ROB_DEPTH - ALMOST_FULL_SLACK)));
            end
            last_rsp_cycle = cycle;
        end
    endtask

    // ========================================================================
    // Stimulus driven at the falling edge
    // ========================================================================

    task automatic drive_request(input bit go);
        afu_req_valid = go;
        if (go)
        begin
            rng = xorshift32(rng);
            afu_req_addr  = rng[ADDR_WIDTH-1:0];
            afu_req_mdata = rng[ADDR_WIDTH +: MDATA_WIDTH];
            sb_addr.push_back(afu_req_addr);
            sb_mdata.push_back(afu_req_mdata);
            issued++;
            if (af_model_on)
                held_count++;
        end
        prev_req_valid = go;
        prev_req_addr  = afu_req_addr;
    endtask

    // FIU model returning at most one response per cycle with the address as data
    task automatic drive_fiu_rsp();
        int idx;
        fiu_rsp_valid = 1'b0;
        rng = xorshift32(rng);
        if (fiu_mode == FIU_HOLD || pend_tag.size() == 0)
            return;
        if (fiu_mode == FIU_RANDOM && rng[1:0] == 2'b00)
            return;
        if (fiu_mode == FIU_REVERSE)
            idx = pend_tag.size() - 1;
        else
            idx = int'(rng[31:16]) % pend_tag.size();
        fiu_rsp_valid = 1'b1;
        fiu_rsp_tag   = pend_tag[idx];
        fiu_rsp_data  = {4{pend_addr[idx]}};
        pend_tag.delete(idx);
        pend_addr.delete(idx);
        last_strobe_cycle = cycle;
    endtask

    task automatic run_cycle(input req_mode_t mode);
        bit go;
        @(negedge clk);
        cycle++;
        watch_fiu_req();
        watch_afu_rsp();
        if (af_model_on)
            check_value("afu_almost_full", 64'(afu_almost_full),
                        64'(held_count >= (ROB_DEPTH - ALMOST_FULL_SLACK)));
        rng = xorshift32(rng);
        case (mode)
            REQ_RANDOM: go = !afu_almost_full && rng[0];
            REQ_GATED:  go = !afu_almost_full;
            REQ_FORCE:  go = 1'b1;
            default:    go = 1'b0;
        endcase
        drive_request(go);
        drive_fiu_rsp();
    endtask

    task automatic drain_all();
        int guard;
        guard = 0;
        while (sb_addr.size() != 0 || pend_tag.size() != 0)
        begin
            run_cycle(REQ_OFF);
            guard++;
            if (guard > 1000)
                report_error("timeout waiting for outstanding reads to drain");
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial
    begin
        int guard;
        int start;
        rst               = 1'b1;
        afu_req_valid     = 1'b0;
        afu_req_addr      = '0;
        afu_req_mdata     = '0;
        fiu_rsp_valid     = 1'b0;
        fiu_rsp_tag       = '0;
        fiu_rsp_data      = '0;
        rng               = 32'hf4568a04;
        cycle             = 0;
        issued            = 0;
        rsp_count         = 0;
        prev_req_valid    = 1'b0;
        prev_req_addr     = '0;
        exp_tag           = '0;
        fiu_mode          = FIU_HOLD;
        af_model_on       = 1'b0;
        held_count        = 0;
        burst_on          = 1'b0;
        burst_base        = 0;
        last_strobe_cycle = 0;
        last_rsp_cycle    = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("afu_almost_full", 64'(afu_almost_full), 64'(0));
        check_value("fiu_req_valid", 64'(fiu_req_valid), 64'(0));
        check_value("afu_rsp_valid", 64'(afu_rsp_valid), 64'(0));

        // Short random run with responses out of order
        fiu_mode = FIU_RANDOM;
        guard    = 0;
        while (issued < 200)
        begin
            run_cycle(REQ_RANDOM);
            guard++;
            if (guard > 5000)
                report_error("timeout issuing the first random reads");
        end
        drain_all();

        // Withhold every response and fill the reorder buffer
        fiu_mode    = FIU_HOLD;
        af_model_on = 1'b1;
        held_count  = 0;
        guard       = 0;
        while (!afu_almost_full)
        begin
            run_cycle(REQ_GATED);
            guard++;
            if (guard > 4 * ROB_DEPTH)
                report_error("timeout waiting for afu_almost_full to rise");
        end
        repeat (ALMOST_FULL_SLACK) run_cycle(REQ_FORCE);
        repeat (4) run_cycle(REQ_OFF);
        af_model_on = 1'b0;

        // Release them all newest first so the head comes back last
        burst_on   = 1'b1;
        burst_base = rsp_count;
        fiu_mode   = FIU_REVERSE;
        drain_all();
        burst_on = 1'b0;
        check_value("burst responses", 64'(rsp_count - burst_base), 64'(ROB_DEPTH));
        check_value("afu_almost_full", 64'(afu_almost_full), 64'(0));

        // Long random run throttled by almost-full
        fiu_mode = FIU_RANDOM;
        start    = issued;
        guard    = 0;
        while (issued - start < 2000)
        begin
            run_cycle(REQ_RANDOM);
            guard++;
            if (guard > 40000)
                report_error("timeout during the long random run");
        end
        drain_all();
        repeat (8) run_cycle(REQ_OFF);
        // With every slot released the stack must be idle again
        check_value("afu_almost_full", 64'(afu_almost_full), 64'(0));

        $display("Test OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/mpf_pkg.sv
hdl/mpf_slot_alloc.sv
hdl/mpf_reorder_buf.sv
hdl/mpf_rsp_drain.sv
hdl/mpf_lite.sv
tests/mpf_lite_sva.sv
tests/tb_mpf_lite.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_mpf_lite
FILELIST  := filelist.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG  := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
